/* icache.f */
source/icache_cfg_pkg.sv
source/mem_msg_pkg.sv
source/msg_queue.sv
source/queue_arbiter.sv
source/cache_bank.sv
source/icache_top.sv
dv/icache_mem_model.sv
dv/icache_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module icache_tb -f icache.f --Mdir obj_dir
	./obj_dir/Vicache_tb | tee sim.log
	grep -q "^Simulation passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* dv/icache_tb.sv */
module icache_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import icache_cfg_pkg::*;
    import mem_msg_pkg::*;

    logic               clk;
    logic               arst_n;
    logic [31:0]        addr_even, addr_odd;
    logic [31:0]        addr_out_even, addr_out_odd;
    logic [cl_size-1:0] cl_even, cl_odd;
    logic               hit_even, hit_odd;
    logic               is_write_even, is_write_odd;
    logic               stall;
    mem_msg_t           data_msg_even, data_msg_odd;
    mem_msg_t           instr_msg_even, instr_msg_odd;
    mem_msg_t           miss_msg_even, miss_msg_odd;
    logic               data_alloc_even, data_alloc_odd;
    logic               instr_alloc_even, instr_alloc_odd;
    logic               data_full_even, data_full_odd;
    logic               instr_full_even, instr_full_odd;
    logic               miss_alloc_even, miss_alloc_odd;
    logic               miss_full_even, miss_full_odd;
    logic               stuck_even, stuck_odd;
    logic [31:0]        rand_state;
    int                 test_errors, pass_count, fail_count;

    icache_top icache_top_i (.*);

    // Fills come back through each bank's data queue
    icache_mem_model mem_even (
        .clk, .miss_msg(miss_msg_even), .miss_alloc(miss_alloc_even),
        .data_full(data_full_even), .data_msg(data_msg_even),
        .data_alloc(data_alloc_even), .stuck(stuck_even)
    );
    icache_mem_model mem_odd (
        .clk, .miss_msg(miss_msg_odd), .miss_alloc(miss_alloc_odd),
        .data_full(data_full_odd), .data_msg(data_msg_odd),
        .data_alloc(data_alloc_odd), .stuck(stuck_odd)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // Line address repeated across the line
    function automatic logic [cl_size-1:0] line_pattern(input logic [31:0] addr);
        return {4{addr[31:offset_bits], {offset_bits{1'b0}}}};
    endfunction

    task automatic next_sample();
        @(negedge clk);
        #25;   // Settled, before the next rising edge
    endtask

    task automatic check_eq(input string name, input logic [127:0] got,
                            input logic [127:0] exp);
        assert (got === exp) else begin
            $display("Error: %s is %0h, expected %0h", name, got, exp);
            test_errors++;
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        assert (cond) else begin
            $display("%s", what);
            test_errors++;
        end
    endtask

    task automatic wait_idle();
        int n = 0;
        while (stall && n < 200) begin
            next_sample();
            n++;
        end
        expect_true(!stall, "Timed out waiting for stall to fall");
    endtask

    task automatic finish_test(input string name);
        $display("%-16s %s (%0d errors)", name, test_errors == 0 ? "ok" : "FAILED", test_errors);
        pass_count += (test_errors == 0);
        fail_count += (test_errors != 0);
        test_errors = 0;
    endtask

    initial begin
        logic [31:0] a, b;
        int          n, pulses;
        arst_n           = 1'b0;
        addr_even        = 32'h0000_0000;
        addr_odd         = 32'h0000_0010;   // Bit 4 set for the odd bank
        instr_msg_even   = '0;
        instr_msg_odd    = '0;
        instr_alloc_even = 1'b0;
        instr_alloc_odd  = 1'b0;
        miss_full_even   = 1'b0;
        miss_full_odd    = 1'b0;
        rand_state       = 32'h23e;
        test_errors      = 0;
        pass_count       = 0;
        fail_count       = 0;
        repeat (10) @(negedge clk);
        arst_n = 1'b1;
        #25;
        check_eq("stall", stall, 0);
        check_eq("miss_alloc_even/odd", {miss_alloc_even, miss_alloc_odd}, 0);
        check_eq("hit_even/odd", {hit_even, hit_odd}, 0);
        check_eq("is_write_even/odd", {is_write_even, is_write_odd}, 0);
        check_eq("data_full/instr_full", {data_full_even, data_full_odd,
                 instr_full_even, instr_full_odd}, 0);
        finish_test("reset");

        // Default addresses miss right after reset
        next_sample();
        wait_idle();
        a = 32'h0000_1244;
        @(negedge clk);
        addr_even = a;
        next_sample();
        check_eq("hit_even", hit_even, 0);
        check_eq("stall", stall, 1);
        check_eq("miss_alloc_even", miss_alloc_even, 1);
        check_eq("miss_msg_even.op", miss_msg_even.op, rd);
        check_eq("miss_msg_even.addr", miss_msg_even.addr, {a[31:4], 4'h0});
        check_eq("miss_msg_even.src", miss_msg_even.src, icache);
        check_eq("miss_msg_even.dest", miss_msg_even.dest, dram);
        next_sample();
        check_eq("miss_alloc_even", miss_alloc_even, 0);
        wait_idle();
        finish_test("cold miss");

        next_sample();   // Address still held, fetched again
        check_eq("hit_even", hit_even, 1);
        check_eq("is_write_even", is_write_even, 0);
        check_eq("addr_out_even", addr_out_even, a);
        check_eq("cl_even", cl_even, line_pattern(a));
        finish_test("hit after fill");

        @(negedge clk);
        instr_msg_even.addr = a;
        instr_msg_even.op   = inv;
        instr_msg_even.src  = directory;
        instr_msg_even.dest = icache;
        instr_alloc_even    = 1'b1;
        @(negedge clk);
        instr_alloc_even = 1'b0;
        #25;
        n = 0;
        while (!is_write_even && n < 200) begin
            next_sample();
            n++;
        end
        expect_true(is_write_even, "Timed out waiting for the invalidate result");
        check_eq("addr_out_even", addr_out_even, a);
        next_sample();
        check_eq("hit_even", hit_even, 0);
        check_eq("stall", stall, 1);
        wait_idle();
        finish_test("invalidate");

        for (int r = 0; r < 4; r++) begin
            rand_state = xorshift(rand_state);
            a = {rand_state[31:5], 1'b0, rand_state[3:0]};
            rand_state = xorshift(rand_state);
            b = {rand_state[31:5], 1'b1, rand_state[3:0]};
            @(negedge clk);
            addr_even = a;
            addr_odd  = b;
            #25;
            n = 0;
            while (!(hit_even && hit_odd && addr_out_even == a && addr_out_odd == b)
                   && n < 200) begin
                // A bank waits while it shows neither a hit nor a write
                check_eq("stall", stall,
                         (!hit_even && !is_write_even) || (!hit_odd && !is_write_odd));
                if (miss_alloc_odd) begin
                    check_eq("miss_msg_odd.op", miss_msg_odd.op, rd);
                    check_eq("miss_msg_odd.addr", miss_msg_odd.addr, {b[31:4], 4'h0});
                    check_eq("miss_msg_odd.src", miss_msg_odd.src, icache);
                    check_eq("miss_msg_odd.dest", miss_msg_odd.dest, dram);
                end
                next_sample();
                n++;
            end
            expect_true(hit_even && hit_odd, "Timed out waiting for both banks to hit");
            check_eq("addr_out_even", addr_out_even, a);
            check_eq("addr_out_odd", addr_out_odd, b);
            check_eq("is_write_even/odd", {is_write_even, is_write_odd}, 0);
            check_eq("cl_even", cl_even, line_pattern(a));
            check_eq("cl_odd", cl_odd, line_pattern(b));
        end
        finish_test("dual banks");

        a = 32'h0000_8040;
        @(negedge clk);
        miss_full_even = 1'b1;
        addr_even      = a;
        next_sample();
        repeat (6) begin
            check_eq("miss_alloc_even", miss_alloc_even, 0);
            check_eq("stall", stall, 1);
            next_sample();
        end
        @(negedge clk);
        miss_full_even = 1'b0;
        #25;
        pulses = 0;
        n = 0;
        while (stall && n < 200) begin
            pulses += int'(miss_alloc_even);
            next_sample();
            n++;
        end
        expect_true(!stall, "Timed out waiting for the held miss to be filled");
        check_eq("miss_alloc_even pulses", pulses, 1);
        finish_test("back-pressure");

        $display("Tests: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0 && !stuck_even && !stuck_odd) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* dv/icache_mem_model.sv */
module icache_mem_model #(
    parameter logic [31:0] seed = 32'h23e
) (
    input  logic                  clk,
    input  mem_msg_pkg::mem_msg_t miss_msg,
    input  logic                  miss_alloc,
    input  logic                  data_full,
    output mem_msg_pkg::mem_msg_t data_msg,
    output logic                  data_alloc,
    output logic                  stuck
);
    timeunit 1ns;
    timeprecision 1ps;
    import mem_msg_pkg::*;

    logic [31:0] rand_state;
    logic [31:0] fill_addr;
    int          tries;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    initial begin
        data_msg   = '0;
        data_alloc = 1'b0;
        stuck      = 1'b0;
        rand_state = seed;
        forever begin
            @(negedge clk);
            #25;   // Just ahead of the rising edge
            if (miss_alloc) begin
                fill_addr  = miss_msg.addr;
                rand_state = xorshift(rand_state);
                repeat (2 + int'(rand_state[2:0])) @(negedge clk);
                tries = 0;
                while (data_full && tries < 20) begin
                    @(negedge clk);
                    tries++;
                end
                if (data_full) begin
                    $display("Memory model gave up, the data queue stayed full");
                    stuck = 1'b1;
                end
                data_msg      = '0;
                data_msg.addr = fill_addr;
                data_msg.op   = st;   // Fill reply
                data_msg.src  = dram;
                data_msg.dest = icache;
                data_msg.line = {4{fill_addr}};
                data_alloc    = !data_full;
                @(negedge clk);
                data_alloc = 1'b0;
            end
        end
    end

endmodule

/* source/icache_top.sv */
module icache_top (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic [31:0]                        addr_even,
    input  logic [31:0]                        addr_odd,
    output logic                               hit_even,
    output logic                               hit_odd,
    output logic [icache_cfg_pkg::cl_size-1:0] cl_even,
    output logic [icache_cfg_pkg::cl_size-1:0] cl_odd,
    output logic [31:0]                        addr_out_even,
    output logic [31:0]                        addr_out_odd,
    output logic                               is_write_even,
    output logic                               is_write_odd,
    output logic                               stall,

    // Even bank memory side
    input  mem_msg_pkg::mem_msg_t              data_msg_even,
    input  mem_msg_pkg::mem_msg_t              instr_msg_even,
    input  logic                               data_alloc_even,
    input  logic                               instr_alloc_even,
    output logic                               data_full_even,
    output logic                               instr_full_even,
    output mem_msg_pkg::mem_msg_t              miss_msg_even,
    output logic                               miss_alloc_even,
    input  logic                               miss_full_even,

    // Odd bank memory side
    input  mem_msg_pkg::mem_msg_t              data_msg_odd,
    input  mem_msg_pkg::mem_msg_t              instr_msg_odd,
    input  logic                               data_alloc_odd,
    input  logic                               instr_alloc_odd,
    output logic                               data_full_odd,
    output logic                               instr_full_odd,
    output mem_msg_pkg::mem_msg_t              miss_msg_odd,
    output logic                               miss_alloc_odd,
    input  logic                               miss_full_odd
);
    import mem_msg_pkg::*;

    mem_msg_t data_head_even;
    mem_msg_t instr_head_even;
    mem_msg_t req_even;
    logic     data_valid_even;
    logic     instr_valid_even;
    logic     data_dealloc_even;
    logic     instr_dealloc_even;
    logic     req_valid_even;
    logic     stall_even;

    mem_msg_t data_head_odd;
    mem_msg_t instr_head_odd;
    mem_msg_t req_odd;
    logic     data_valid_odd;
    logic     instr_valid_odd;
    logic     data_dealloc_odd;
    logic     instr_dealloc_odd;
    logic     req_valid_odd;
    logic     stall_odd;

    assign stall = stall_even || stall_odd;   // Either bank waiting holds the pipeline

    msg_queue data_q_even (
        .clk, .arst_n, .in_msg(data_msg_even), .alloc(data_alloc_even),
        .full(data_full_even), .head(data_head_even), .valid(data_valid_even),
        .dealloc(data_dealloc_even)
    );

    msg_queue instr_q_even (
        .clk, .arst_n, .in_msg(instr_msg_even), .alloc(instr_alloc_even),
        .full(instr_full_even), .head(instr_head_even), .valid(instr_valid_even),
        .dealloc(instr_dealloc_even)
    );

    queue_arbiter queue_arb_even (
        .data_head(data_head_even), .instr_head(instr_head_even),
        .data_valid(data_valid_even), .instr_valid(instr_valid_even),
        .fetch_addr(addr_even), .stall(stall_even),
        .req(req_even), .req_valid(req_valid_even),
        .data_dealloc(data_dealloc_even), .instr_dealloc(instr_dealloc_even)
    );

    cache_bank cache_bank_even (
        .clk, .arst_n, .req(req_even), .req_valid(req_valid_even),
        .addr_out(addr_out_even), .line(cl_even), .hit(hit_even),
        .is_write(is_write_even), .stall(stall_even),
        .miss_msg(miss_msg_even), .miss_alloc(miss_alloc_even), .miss_full(miss_full_even)
    );

    msg_queue data_q_odd (
        .clk, .arst_n, .in_msg(data_msg_odd), .alloc(data_alloc_odd),
        .full(data_full_odd), .head(data_head_odd), .valid(data_valid_odd),
        .dealloc(data_dealloc_odd)
    );

    msg_queue instr_q_odd (
        .clk, .arst_n, .in_msg(instr_msg_odd), .alloc(instr_alloc_odd),
        .full(instr_full_odd), .head(instr_head_odd), .valid(instr_valid_odd),
        .dealloc(instr_dealloc_odd)
    );

    queue_arbiter queue_arb_odd (
        .data_head(data_head_odd), .instr_head(instr_head_odd),
        .data_valid(data_valid_odd), .instr_valid(instr_valid_odd),
        .fetch_addr(addr_odd), .stall(stall_odd),
        .req(req_odd), .req_valid(req_valid_odd),
        .data_dealloc(data_dealloc_odd), .instr_dealloc(instr_dealloc_odd)
    );

    cache_bank cache_bank_odd (
        .clk, .arst_n, .req(req_odd), .req_valid(req_valid_odd),
        .addr_out(addr_out_odd), .line(cl_odd), .hit(hit_odd),
        .is_write(is_write_odd), .stall(stall_odd),
        .miss_msg(miss_msg_odd), .miss_alloc(miss_alloc_odd), .miss_full(miss_full_odd)
    );

endmodule

/* source/cache_bank.sv */
module cache_bank (
    input  logic                               clk,
    input  logic                               arst_n,
    input  mem_msg_pkg::mem_msg_t              req,
    input  logic                               req_valid,
    output logic [31:0]                        addr_out,
    output logic [icache_cfg_pkg::cl_size-1:0] line,
    output logic                               hit,
    output logic                               is_write,
    output logic                               stall,
    output mem_msg_pkg::mem_msg_t              miss_msg,
    output logic                               miss_alloc,
    input  logic                               miss_full
);
    import icache_cfg_pkg::*;
    import mem_msg_pkg::*;

    typedef enum logic {
        idle,
        wait_fill
    } state_t;

    state_t              state;
    logic                sent;        // Miss request already went out
    fetch_addr_t         req_addr;
    fetch_addr_t         miss_addr;   // Line address of the pending miss
    logic [idx_cnt-1:0]  valid_bits;
    logic [tag_bits-1:0] tags [idx_cnt];
    logic [cl_size-1:0]  lines [idx_cnt];
    logic [idx_bits-1:0] idx;
    logic                tag_match;
    logic                is_ld;
    logic                is_fill;
    logic                is_inv;
    logic                fill_match;
    logic                start_miss;

    assign req_addr = req.addr;
    assign idx      = req_addr.fields.index;

    assign tag_match = valid_bits[idx] && (tags[idx] == req_addr.fields.tag);

    assign is_ld   = req_valid && (req.op == ld);
    assign is_fill = req_valid && (req.op == st);
    assign is_inv  = req_valid && (req.op == inv);

    // Fill for the line we are stalled on
    assign fill_match = (state == wait_fill) &&
                        (req_addr.raw[31:offset_bits] == miss_addr.raw[31:offset_bits]);

    assign start_miss = (state == idle) && is_ld && !tag_match;

    assign stall      = (state == wait_fill);
    assign miss_alloc = (state == wait_fill) && !sent && !miss_full;

    // Read request for the whole line, straight to DRAM
    always_comb begin
        miss_msg      = '0;
        miss_msg.addr = miss_addr.raw;
        miss_msg.op   = rd;
        miss_msg.src  = icache;
        miss_msg.dest = dram;
    end

    // Tag and line store, plus the result payload
    always_ff @(posedge clk) begin
        if (is_fill) begin
            tags[idx]  <= req_addr.fields.tag;
            lines[idx] <= req.line;
        end
        if (req_valid) begin
            addr_out <= req.addr;
            line     <= is_fill ? req.line : lines[idx];
        end
        if (start_miss) begin
            miss_addr.raw <= {req_addr.raw[31:offset_bits], {offset_bits{1'b0}}};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= idle;
            sent       <= 1'b0;
            valid_bits <= '0;
            hit        <= 1'b0;
            is_write   <= 1'b0;
        end else begin
            hit      <= is_ld && tag_match;
            is_write <= req_valid && (req.op != ld);   // Anything but a fetch

            if (is_fill) begin
                valid_bits[idx] <= 1'b1;
            end else if (is_inv && tag_match) begin
                valid_bits[idx] <= 1'b0;
            end

            case (state)
                idle: begin
                    if (start_miss) begin
                        state <= wait_fill;
                        sent  <= 1'b0;
                    end
                end
                wait_fill: begin
                    if (miss_alloc) begin
                        sent <= 1'b1;
                    end
                    if (is_fill && fill_match) begin
                        state <= idle;   // Line is in, release the pipeline
                    end
                end
                default: state <= idle;
            endcase
        end
    end

endmodule

/* source/queue_arbiter.sv */
module queue_arbiter (
    input  mem_msg_pkg::mem_msg_t data_head,
    input  mem_msg_pkg::mem_msg_t instr_head,
    input  logic                  data_valid,
    input  logic                  instr_valid,
    input  logic [31:0]           fetch_addr,
    input  logic                  stall,
    output mem_msg_pkg::mem_msg_t req,
    output logic                  req_valid,
    output logic                  data_dealloc,
    output logic                  instr_dealloc
);
    import mem_msg_pkg::*;

    mem_msg_t fetch_msg;

    // Pipeline fetch wrapped as a load from the icache port
    always_comb begin
        fetch_msg          = '0;
        fetch_msg.addr     = fetch_addr;
        fetch_msg.op       = ld;
        fetch_msg.src      = icache;
        fetch_msg.dest     = icache;
    end

    // Fills beat invalidations, both beat the pipeline
    always_comb begin
        req           = fetch_msg;
        req_valid     = 1'b0;
        data_dealloc  = 1'b0;
        instr_dealloc = 1'b0;
        if (data_valid) begin
            req          = data_head;
            req_valid    = 1'b1;
            data_dealloc = 1'b1;
        end else if (instr_valid) begin
            req           = instr_head;
            req_valid     = 1'b1;
            instr_dealloc = 1'b1;
        end else if (!stall) begin
            req_valid = 1'b1;   // Fetch only while the bank is not waiting
        end
    end

endmodule

/* source/msg_queue.sv */
module msg_queue (
    input  logic                  clk,
    input  logic                  arst_n,
    input  mem_msg_pkg::mem_msg_t in_msg,
    input  logic                  alloc,
    output logic                  full,
    output mem_msg_pkg::mem_msg_t head,
    output logic                  valid,
    input  logic                  dealloc
);
    import mem_msg_pkg::*;

    mem_msg_t entries [queue_depth];

    logic [$clog2(queue_depth)-1:0] wr_ptr;
    logic [$clog2(queue_depth)-1:0] rd_ptr;
    logic [$clog2(queue_depth):0]   count;   // One extra bit to tell full from empty
    logic                           push;
    logic                           pop;

    assign full  = (count == queue_depth);
    assign valid = (count != '0);

    // An alloc while full is simply dropped
    assign push = alloc && !full;
    assign pop  = dealloc && valid;

    assign head = entries[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= in_msg;
        end
    end

    // Depth is a power of two, pointers wrap by themselves
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* source/mem_msg_pkg.sv */
package mem_msg_pkg;

    // Memory operations; a fill reply comes back as st
    typedef enum logic [2:0] {
        no_op = 3'd0,
        ld    = 3'd1,
        st    = 3'd2,
        rd    = 3'd3,
        wr    = 3'd4,
        inv   = 3'd5,
        upd   = 3'd6,
        rwitm = 3'd7
    } mem_op_t;

    // Who sends or receives a message
    typedef enum logic [1:0] {
        no_port   = 2'd0,
        icache    = 2'd1,
        directory = 2'd2,
        dram      = 2'd3
    } port_id_t;

    // One message on a memory queue
    typedef struct packed {
        logic [31:0]                        addr;
        mem_op_t                            op;
        port_id_t                           src;
        port_id_t                           dest;
        logic                               is_flush;
        logic [icache_cfg_pkg::cl_size-1:0] line;   // Only meaningful for fills
    } mem_msg_t;

    localparam int queue_depth = 8;  // Entries per inbound queue

endpackage

/* source/icache_cfg_pkg.sv */
package icache_cfg_pkg;

    // Line geometry
    localparam int cl_size     = 128;
    localparam int offset_bits = 4;

    // Bit 4 picks the bank, so each bank only sees half the lines
    localparam int bank_bits   = 1;
    localparam int idx_bits    = 4;
    localparam int tag_bits    = 32 - idx_bits - bank_bits - offset_bits;

    localparam int idx_cnt     = 1 << idx_bits;  // Lines per bank

    // Fetch address, seen either as a plain word or split into its fields
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [tag_bits-1:0]    tag;
            logic [idx_bits-1:0]    index;
            logic [bank_bits-1:0]   bank;
            logic [offset_bits-1:0] offset;
        } fields;
    } fetch_addr_t;

endpackage
